//--- src/cluster_defs.svh
`ifndef CLUSTER_DEFS_SVH
`define CLUSTER_DEFS_SVH

// Cluster shape
`define NUM_SOCKETS     2

// Bus widths
`define ADDR_WIDTH      16
`define DATA_WIDTH      32
`define DCR_ADDR_WIDTH  8

// Socket tag, at least one bit even for a single socket
`define TAG_WIDTH       (($clog2(`NUM_SOCKETS) > 0) ? $clog2(`NUM_SOCKETS) : 1)

// Base-state DCR range, end is exclusive
`define DCR_BASE_BEGIN  8'h10
`define DCR_BASE_END    8'h20

// Base-state registers
`define DCR_SRC_ADDR    8'h10
`define DCR_LENGTH      8'h11
`define DCR_DST_ADDR    8'h12
// Write of any data kicks off every idle socket
`define DCR_START       8'h13

`endif

//--- src/cluster_pkg.sv
`include "cluster_defs.svh"

package cluster_pkg;

    // Host configuration write, one cycle strobe
    typedef struct packed {
        logic                       valid;
        logic [`DCR_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
    } dcr_write_t;

    // External memory request, tagged with the issuing socket
    typedef struct packed {
        logic                   valid;
        logic                   rw;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
        logic [`TAG_WIDTH-1:0]  tag;
    } mem_req_t;

    // Read response, may come back out of order
    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] data;
        logic [`TAG_WIDTH-1:0]  tag;
    } mem_rsp_t;

    // Socket side request, tag added by the arbiter
    typedef struct packed {
        logic                   valid;
        logic                   rw;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
    } sock_req_t;

endpackage

//--- src/dcr_router.sv
`timescale 1ns/1ps
`include "cluster_defs.svh"

module dcr_router (
    input  logic                    clk,
    input  logic                    rst,
    input  cluster_pkg::dcr_write_t dcr_write,
    output cluster_pkg::dcr_write_t base_dcr_write
);

    logic in_range;

    assign in_range = (dcr_write.addr >= `DCR_BASE_BEGIN)
                   && (dcr_write.addr < `DCR_BASE_END);

    // One register stage feeds every socket
    always_ff @(posedge clk) begin
        base_dcr_write.addr <= dcr_write.addr;
        base_dcr_write.data <= dcr_write.data;
        if (rst) begin
            base_dcr_write.valid <= 1'b0;
        end else begin
            base_dcr_write.valid <= dcr_write.valid && in_range;
        end
    end

    // Sockets only ever see base-state addresses
    assert property (
        @(posedge clk) disable iff (rst)
        base_dcr_write.valid |->
            (base_dcr_write.addr >= `DCR_BASE_BEGIN)
            && (base_dcr_write.addr < `DCR_BASE_END)
    );

endmodule

//--- src/socket.sv
`timescale 1ns/1ps
`include "cluster_defs.svh"

module socket #(
    parameter int SOCKET_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cluster_pkg::dcr_write_t dcr_write,
    output cluster_pkg::sock_req_t  sock_req,
    input  logic                    grant,
    input  logic                    rsp_valid,
    input  logic [`DATA_WIDTH-1:0]  rsp_data,
    output logic                    busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_WRITE
    } state_t;

    state_t state;

    // Base state as last written by the host
    logic [`ADDR_WIDTH-1:0] src_addr;
    logic [`ADDR_WIDTH-1:0] length;
    logic [`ADDR_WIDTH-1:0] dst_addr;

    // Per-job copies, held from start to finish
    logic [`ADDR_WIDTH-1:0] job_len;
    logic [`ADDR_WIDTH-1:0] rd_addr;
    logic [`ADDR_WIDTH-1:0] wr_addr;
    logic [`DATA_WIDTH-1:0] sum;

    logic [`ADDR_WIDTH-1:0] issue_cnt;
    logic [`ADDR_WIDTH-1:0] rsp_cnt;
    logic [`ADDR_WIDTH-1:0] outstanding;
    logic                   start;

    assign start       = dcr_write.valid && (dcr_write.addr == `DCR_START);
    assign outstanding = issue_cnt - rsp_cnt;
    assign busy        = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (dcr_write.valid) begin
            case (dcr_write.addr)
                `DCR_SRC_ADDR: src_addr <= dcr_write.data[`ADDR_WIDTH-1:0];
                `DCR_LENGTH:   length   <= dcr_write.data[`ADDR_WIDTH-1:0];
                `DCR_DST_ADDR: dst_addr <= dcr_write.data[`ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // Slice start and result slot depend on position in the row
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && start) begin
            job_len <= length;
            rd_addr <= src_addr + `ADDR_WIDTH'(SOCKET_ID) * length;
            wr_addr <= dst_addr + `ADDR_WIDTH'(SOCKET_ID);
            sum     <= '0;
        end else begin
            if ((state == S_ISSUE) && grant) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (rsp_valid) begin
                sum <= sum + rsp_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= S_IDLE;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
        end else begin
            // Responses can land while reads are still going out
            if (rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start) begin
                        issue_cnt <= '0;
                        rsp_cnt   <= '0;
                        // Empty slice goes straight to the result write
                        state     <= (length == '0) ? S_WRITE : S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (grant) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (issue_cnt == job_len - 1'b1) begin
                            state <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (rsp_cnt == job_len) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (grant) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        sock_req.valid = (state == S_ISSUE) || (state == S_WRITE);
        sock_req.rw    = (state == S_WRITE);
        sock_req.addr  = (state == S_WRITE) ? wr_addr : rd_addr;
        sock_req.data  = (state == S_WRITE) ? sum : '0;
    end

    // Every response belongs to a read this socket has in flight
    assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid |-> (outstanding != '0)
    );

    // Pending request holds until the arbiter takes it
    assert property (
        @(posedge clk) disable iff (rst)
        (sock_req.valid && !grant) |=> $stable(sock_req)
    );

endmodule

//--- src/mem_arb.sv
`timescale 1ns/1ps
`include "cluster_defs.svh"

module mem_arb (
    input  logic                   clk,
    input  logic                   rst,
    input  cluster_pkg::sock_req_t sock_req [`NUM_SOCKETS],
    output logic [`NUM_SOCKETS-1:0] grant,
    output logic [`NUM_SOCKETS-1:0] sock_rsp_valid,
    output logic [`DATA_WIDTH-1:0]  sock_rsp_data,
    output cluster_pkg::mem_req_t   mem_req,
    input  cluster_pkg::mem_rsp_t   mem_rsp
);

    localparam int TW = `TAG_WIDTH;

    // Socket with top priority this cycle
    logic [TW-1:0] rr_ptr;
    logic [TW-1:0] win_idx;
    logic          found;

    always_comb begin
        int idx;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < `NUM_SOCKETS; i++) begin
            idx = (int'(rr_ptr) + i) % `NUM_SOCKETS;
            if (!found && sock_req[idx].valid) begin
                found   = 1'b1;
                win_idx = idx[TW-1:0];
            end
        end
        if (found) begin
            grant[win_idx] = 1'b1;
        end
    end

    // Priority moves to the socket after the winner
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= '0;
        end else if (found) begin
            if (win_idx == TW'(`NUM_SOCKETS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= win_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_req.rw   <= sock_req[win_idx].rw;
        mem_req.addr <= sock_req[win_idx].addr;
        mem_req.data <= sock_req[win_idx].data;
        mem_req.tag  <= win_idx;
        if (rst) begin
            mem_req.valid <= 1'b0;
        end else begin
            mem_req.valid <= found;
        end
    end

    // Response data is shared, the tag picks the one socket that sees valid
    always_ff @(posedge clk) begin
        sock_rsp_data <= mem_rsp.data;
        if (rst) begin
            sock_rsp_valid <= '0;
        end else begin
            for (int i = 0; i < `NUM_SOCKETS; i++) begin
                sock_rsp_valid[i] <= mem_rsp.valid && (mem_rsp.tag == TW'(i));
            end
        end
    end

    assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant)
    );

endmodule

//--- src/cluster.sv
`timescale 1ns/1ps
`include "cluster_defs.svh"

module cluster (
    input  logic                    clk,
    input  logic                    rst,
    input  cluster_pkg::dcr_write_t dcr_write,
    output cluster_pkg::mem_req_t   mem_req,
    input  cluster_pkg::mem_rsp_t   mem_rsp,
    output logic                    busy
);

    cluster_pkg::dcr_write_t base_dcr_write;
    cluster_pkg::sock_req_t  sock_req [`NUM_SOCKETS];

    logic [`NUM_SOCKETS-1:0] grant;
    logic [`NUM_SOCKETS-1:0] sock_rsp_valid;
    logic [`DATA_WIDTH-1:0]  sock_rsp_data;
    logic [`NUM_SOCKETS-1:0] socket_busy;

    // Base-state decode, one broadcast copy for the row
    dcr_router dcr_router_i (
        .clk            (clk),
        .rst            (rst),
        .dcr_write      (dcr_write),
        .base_dcr_write (base_dcr_write)
    );

    for (genvar i = 0; i < `NUM_SOCKETS; i++) begin : g_socket
        socket #(
            .SOCKET_ID (i)
        ) socket_i (
            .clk       (clk),
            .rst       (rst),
            .dcr_write (base_dcr_write),
            .sock_req  (sock_req[i]),
            .grant     (grant[i]),
            .rsp_valid (sock_rsp_valid[i]),
            .rsp_data  (sock_rsp_data),
            .busy      (socket_busy[i])
        );
    end

    // All socket traffic merged onto the single memory port
    mem_arb mem_arb_i (
        .clk            (clk),
        .rst            (rst),
        .sock_req       (sock_req),
        .grant          (grant),
        .sock_rsp_valid (sock_rsp_valid),
        .sock_rsp_data  (sock_rsp_data),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp)
    );

    assign busy = |socket_busy;

endmodule

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps
`include "cluster_defs.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  cluster_pkg::mem_req_t mem_req,
    output cluster_pkg::mem_rsp_t mem_rsp
);

    logic [`DATA_WIDTH-1:0] mem [0:(1 << `ADDR_WIDTH) - 1];

    // Every accepted request, in arrival order
    cluster_pkg::mem_req_t rd_log [$];
    cluster_pkg::mem_req_t wr_log [$];

    // Reads in flight, answered once their due cycle is reached
    logic [`DATA_WIDTH-1:0] pend_data [$];
    logic [`TAG_WIDTH-1:0]  pend_tag [$];
    int                     pend_due [$];

    cluster_pkg::mem_rsp_t rsp_q = '0;
    int                    cycle_cnt = 0;

    assign mem_rsp = rsp_q;

    task automatic fill_random();
        for (int a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            mem[a] = $urandom ^ {a[15:0], ~a[15:0]};
        end
    endtask

    task automatic clear_logs();
        rd_log.delete();
        wr_log.delete();
    endtask

    always @(posedge clk) begin
        int pick;
        #1;
        pick = -1;
        if (rst) begin
            rsp_q = '0;
            pend_data.delete();
            pend_tag.delete();
            pend_due.delete();
            cycle_cnt = 0;
        end else begin
            cycle_cnt++;
            if (mem_req.valid && mem_req.rw) begin
                wr_log.push_back(mem_req);
                mem[mem_req.addr] = mem_req.data;
            end else if (mem_req.valid) begin
                rd_log.push_back(mem_req);
                pend_data.push_back(mem[mem_req.addr]);
                pend_tag.push_back(mem_req.tag);
                // 1 to 4 cycles, so a later read can overtake an earlier one
                pend_due.push_back(cycle_cnt + 1 + int'($urandom % 4));
            end
            // One response strobe per cycle at most
            for (int j = 0; j < pend_due.size(); j++) begin
                if ((pick < 0) && (pend_due[j] <= cycle_cnt)) begin
                    pick = j;
                end
            end
            rsp_q = '0;
            if (pick >= 0) begin
                rsp_q.valid = 1'b1;
                rsp_q.data  = pend_data[pick];
                rsp_q.tag   = pend_tag[pick];
                pend_data.delete(pick);
                pend_tag.delete(pick);
                pend_due.delete(pick);
            end
        end
    end

endmodule

//--- tests/tb_cluster.sv
`timescale 1ns/1ps
`include "cluster_defs.svh"

module tb_cluster;

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] src;
        logic [`ADDR_WIDTH-1:0] len;
        logic [`ADDR_WIDTH-1:0] dst;
        logic [15:0]            exp_reads;
    } job_t;

    localparam int NUM_JOBS = 6;
    localparam int MAX_LEN = 9;
    localparam int TW = `TAG_WIDTH;
    localparam int WATCHDOG_CYCLES = 200 + 40 * NUM_JOBS * MAX_LEN;
    localparam int IDLE_LIMIT = 40 * MAX_LEN;

    // Source, length, destination, expected read count over both sockets
    localparam job_t JOBS [NUM_JOBS] = '{
        '{src: 16'h0100, len: 16'd4, dst: 16'h2000, exp_reads: 16'd8},
        '{src: 16'h0200, len: 16'd0, dst: 16'h2010, exp_reads: 16'd0},
        '{src: 16'h0300, len: 16'd9, dst: 16'h2020, exp_reads: 16'd18},
        '{src: 16'h0400, len: 16'd1, dst: 16'h2030, exp_reads: 16'd2},
        '{src: 16'hfff0, len: 16'd7, dst: 16'h2040, exp_reads: 16'd14},
        '{src: 16'h0500, len: 16'd5, dst: 16'h2050, exp_reads: 16'd10}
    };

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    busy;
    cluster_pkg::dcr_write_t dcr_write;
    cluster_pkg::mem_req_t   mem_req;
    cluster_pkg::mem_rsp_t   mem_rsp;

    cluster uut (
        .clk       (clk),
        .rst       (rst),
        .dcr_write (dcr_write),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .busy      (busy)
    );

    tb_mem_model mem_i (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_req(input string name, input cluster_pkg::mem_req_t got,
                             input cluster_pkg::mem_req_t exp);
        if ((got.rw !== exp.rw) || (got.addr !== exp.addr) || (got.tag !== exp.tag)) begin
            $display("mismatch at %0t: %s rw/addr/tag got %b/%h/%0d expected %b/%h/%0d",
                     $time, name, got.rw, got.addr, got.tag, exp.rw, exp.addr, exp.tag);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] got,
                              input logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_busy(input logic exp);
        if (busy !== exp) begin
            $display("mismatch at %0t: busy got %b expected %b", $time, busy, exp);
            stop_run();
        end
    endtask

    task automatic write_dcr(input logic [`DCR_ADDR_WIDTH-1:0] addr,
                             input logic [`DATA_WIDTH-1:0] data);
        dcr_write = '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk);
        #1;
        dcr_write = '0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            n++;
            if (n > IDLE_LIMIT) begin
                $display("busy stayed high for %0d cycles after start", n);
                stop_run();
            end
        end
        // The last result write is logged by the memory model one cycle later
        @(posedge clk);
        #1;
    endtask

    task automatic run_job(input job_t job);
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] exp_sum;
        cluster_pkg::mem_req_t  exp;
        int                     hits;
        int                     pick;
        mem_i.clear_logs();
        write_dcr(`DCR_SRC_ADDR, {16'h0, job.src});
        write_dcr(`DCR_LENGTH, {16'h0, job.len});
        write_dcr(`DCR_DST_ADDR, {16'h0, job.dst});
        // Out-of-range write that must not move the source
        write_dcr(8'h30, {16'h0, job.src ^ 16'h0f0f});
        write_dcr(`DCR_START, 32'h0);
        @(posedge clk);
        #1;
        check_busy(1'b1);
        if (job.len >= 4) begin
            write_dcr(`DCR_START, 32'h0);
        end
        wait_idle();
        check_busy(1'b0);
        check_word("read count", mem_i.rd_log.size(), {16'h0, job.exp_reads});
        check_word("write count", mem_i.wr_log.size(), `NUM_SOCKETS);
        for (int i = 0; i < `NUM_SOCKETS; i++) begin
            exp_sum = '0;
            for (int k = 0; k < int'(job.len); k++) begin
                addr = job.src + 16'(i) * job.len + 16'(k);
                exp_sum = exp_sum + mem_i.mem[addr];
                hits = 0;
                pick = 0;
                foreach (mem_i.rd_log[j]) begin
                    if (mem_i.rd_log[j].addr == addr) begin
                        hits++;
                        pick = j;
                    end
                end
                check_word("reads of slice word", hits, 1);
                exp = '{valid: 1'b1, rw: 1'b0, addr: addr, data: '0, tag: TW'(i)};
                check_req("read request", mem_i.rd_log[pick], exp);
            end
            addr = job.dst + 16'(i);
            hits = 0;
            pick = 0;
            foreach (mem_i.wr_log[j]) begin
                if (mem_i.wr_log[j].addr == addr) begin
                    hits++;
                    pick = j;
                end
            end
            check_word("writes to result slot", hits, 1);
            exp = '{valid: 1'b1, rw: 1'b1, addr: addr, data: exp_sum, tag: TW'(i)};
            check_req("write request", mem_i.wr_log[pick], exp);
            check_word("result data", mem_i.wr_log[pick].data, exp_sum);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the jobs did not finish", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin
        rst = 1'b1;
        dcr_write = '0;
        void'($urandom(32'h59696d1e));
        mem_i.fill_random();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_busy(1'b0);
        check_word("mem_req.valid", {31'h0, mem_req.valid}, 32'h0);
        for (int r = 0; r < NUM_JOBS; r++) begin
            run_job(JOBS[r]);
        end
        $display("No errors");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/cluster_pkg.sv
src/dcr_router.sv
src/socket.sv
src/mem_arb.sv
src/cluster.sv
tests/tb_mem_model.sv
tests/tb_cluster.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator and run the cluster testbench.
# The run passes only when the testbench prints its pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cluster -f flist.f -o sim_cluster \
    && out="$(./obj_dir/sim_cluster 2>&1)"; status=$?; echo "$out"; \
    [ "$status" -eq 0 ] \
    && echo "$out" | grep -qx "No errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
